// File: replay_pkg.sv
`default_nettype none

package replay_pkg;

   // Stream widths
   localparam int DATA_W = 32;
   localparam int KEEP_W = DATA_W / 8;
   localparam int USER_W = 16;

   // Capture memory of 256 words, length counter one bit wider to reach full
   localparam int MEM_ADDR_W = 8;
   localparam int LEN_W      = MEM_ADDR_W + 1;

   // Output FIFO of 8 entries
   localparam int FIFO_DEPTH_BITS = 3;
   localparam int FIFO_DEPTH      = 2 ** FIFO_DEPTH_BITS;

   // Register bus
   localparam int WB_DATA_W = 32;
   localparam int WB_ADDR_W = 4;

   // One stored beat, laid out as {last, user, keep, data}
   typedef struct packed {
      logic              last;
      logic [USER_W-1:0] user;
      logic [KEEP_W-1:0] keep;
      logic [DATA_W-1:0] data;
   } mem_word_t;

   // Register byte addresses
   localparam logic [WB_ADDR_W-1:0] REG_CTRL   = 4'h0;
   localparam logic [WB_ADDR_W-1:0] REG_COUNT  = 4'h4;
   localparam logic [WB_ADDR_W-1:0] REG_STATUS = 4'h8;

   // Control register bits
   localparam int CTRL_START_BIT   = 0;
   localparam int CTRL_SW_RST_BIT  = 1;
   localparam int CTRL_WR_DONE_BIT = 2;

   // Status register fields
   localparam int STATUS_BUSY_BIT = 0;
   localparam int STATUS_LEN_LSB  = 8;

endpackage

`default_nettype wire

// File: pkt_capture.sv
`timescale 1ns/1ns
`default_nettype none

module pkt_capture (
   input  logic                              clk_i,
   input  logic                              arst_n_i,

   input  logic [replay_pkg::DATA_W-1:0]     s_axis_tdata_i,
   input  logic [replay_pkg::KEEP_W-1:0]     s_axis_tkeep_i,
   input  logic [replay_pkg::USER_W-1:0]     s_axis_tuser_i,
   input  logic                              s_axis_tlast_i,
   input  logic                              s_axis_tvalid_i,
   output logic                              s_axis_tready_o,

   input  logic                              wr_done_i,
   input  logic                              sw_rst_i,

   output logic                              mem_we_o,
   output logic [replay_pkg::MEM_ADDR_W-1:0] mem_waddr_o,
   output replay_pkg::mem_word_t             mem_wword_o,
   output logic [replay_pkg::LEN_W-1:0]      stored_len_o
);
   import replay_pkg::*;

   logic [LEN_W-1:0] wr_ptr_q;
   logic             full;
   logic             accept;

   // Top pointer bit set means all words are taken
   assign full = wr_ptr_q[MEM_ADDR_W];

   // Capture is open until wr_done, and closed during a soft reset
   assign s_axis_tready_o = ~wr_done_i & ~full & ~sw_rst_i;
   assign accept          = s_axis_tvalid_i & s_axis_tready_o;

   // The beat is written on the same edge it transfers
   assign mem_we_o    = accept;
   assign mem_waddr_o = wr_ptr_q[MEM_ADDR_W-1:0];

   always_comb begin
      mem_wword_o.last = s_axis_tlast_i;
      mem_wword_o.user = s_axis_tuser_i;
      mem_wword_o.keep = s_axis_tkeep_i;
      mem_wword_o.data = s_axis_tdata_i;
   end

   // Write pointer doubles as the stored length
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         wr_ptr_q <= '0;
      end else if (sw_rst_i) begin
         wr_ptr_q <= '0;
      end else if (accept) begin
         wr_ptr_q <= wr_ptr_q + 1'b1;
      end
   end

   assign stored_len_o = wr_ptr_q;

endmodule

`default_nettype wire

// File: replay_reader.sv
`timescale 1ns/1ns
`default_nettype none

module replay_reader (
   input  logic                              clk_i,
   input  logic                              arst_n_i,
   input  logic                              start_i,
   input  logic                              sw_rst_i,
   input  logic [replay_pkg::WB_DATA_W-1:0]  replay_count_i,
   input  logic [replay_pkg::LEN_W-1:0]      stored_len_i,
   input  logic                              rd_gnt_i,
   input  logic                              fifo_pop_i,
   output logic                              rd_req_o,
   output logic [replay_pkg::MEM_ADDR_W-1:0] rd_addr_o,
   output logic                              busy_o
);
   import replay_pkg::*;

   logic                     issuing_q;
   logic [MEM_ADDR_W-1:0]    last_addr_q;
   logic [WB_DATA_W-1:0]     passes_left_q;
   logic [FIFO_DEPTH_BITS:0] in_use_q;
   logic                     has_credit;
   logic                     last_word;

   // Words in flight plus words held must never exceed the FIFO depth
   assign has_credit = int'(in_use_q) < FIFO_DEPTH;

   // No new read is started in the cycle of a soft reset
   assign rd_req_o  = issuing_q & has_credit & ~sw_rst_i;
   assign last_word = (rd_addr_o == last_addr_q);

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         busy_o        <= 1'b0;
         issuing_q     <= 1'b0;
         rd_addr_o     <= '0;
         last_addr_q   <= '0;
         passes_left_q <= '0;
      end else if (sw_rst_i) begin
         busy_o    <= 1'b0;
         issuing_q <= 1'b0;
      end else begin
         if (start_i && !busy_o) begin
            // Zero passes or an empty memory end the replay at once
            if (replay_count_i != '0 && stored_len_i != '0) begin
               busy_o        <= 1'b1;
               issuing_q     <= 1'b1;
               rd_addr_o     <= '0;
               passes_left_q <= replay_count_i;
               last_addr_q   <= MEM_ADDR_W'(stored_len_i - 1'b1);
            end
         end else if (rd_gnt_i) begin
            if (last_word) begin
               // Wrap to the first word for the next pass
               rd_addr_o     <= '0;
               passes_left_q <= passes_left_q - 1'b1;
               if (passes_left_q == 1) begin
                  issuing_q <= 1'b0;
               end
            end else begin
               rd_addr_o <= rd_addr_o + 1'b1;
            end
         end

         // Done once all reads are issued and the FIFO has drained
         if (busy_o && !issuing_q && in_use_q == '0) begin
            busy_o <= 1'b0;
         end
      end
   end

   // Credit bookkeeping, a grant takes one entry and a pop returns one
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         in_use_q <= '0;
      end else if (sw_rst_i) begin
         in_use_q <= '0;
      end else begin
         case ({rd_gnt_i, fifo_pop_i})
            2'b10:   in_use_q <= in_use_q + 1'b1;
            2'b01:   in_use_q <= in_use_q - 1'b1;
            default: in_use_q <= in_use_q;
         endcase
      end
   end

endmodule

`default_nettype wire

// File: pkt_mem_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module pkt_mem_arbiter (
   input  logic                              clk_i,

   // Capture side
   input  logic                              mem_we_i,
   input  logic [replay_pkg::MEM_ADDR_W-1:0] mem_waddr_i,
   input  replay_pkg::mem_word_t             mem_wword_i,

   // Replay side
   input  logic                              rd_req_i,
   input  logic [replay_pkg::MEM_ADDR_W-1:0] rd_addr_i,
   output logic                              rd_gnt_o,
   output logic                              rd_valid_o,
   output replay_pkg::mem_word_t             rd_word_o
);
   import replay_pkg::*;

   mem_word_t mem_q [2**MEM_ADDR_W];

   // Single port, so a write blocks the read for that cycle
   assign rd_gnt_o = rd_req_i & ~mem_we_i;

   always_ff @(posedge clk_i) begin
      if (mem_we_i) begin
         mem_q[mem_waddr_i] <= mem_wword_i;
      end
   end

   // Read data lands one cycle after the grant
   always_ff @(posedge clk_i) begin
      if (rd_gnt_o) begin
         rd_word_o <= mem_q[rd_addr_i];
      end
   end

   // Marks the cycle in which rd_word_o carries a fresh word
   always_ff @(posedge clk_i) begin
      rd_valid_o <= rd_gnt_o;
   end

endmodule

`default_nettype wire

// File: replay_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module replay_fifo (
   input  logic                          clk_i,
   input  logic                          arst_n_i,
   input  logic                          sw_rst_i,

   input  logic                          rd_valid_i,
   input  replay_pkg::mem_word_t         rd_word_i,

   output logic [replay_pkg::DATA_W-1:0] m_axis_tdata_o,
   output logic [replay_pkg::KEEP_W-1:0] m_axis_tkeep_o,
   output logic [replay_pkg::USER_W-1:0] m_axis_tuser_o,
   output logic                          m_axis_tlast_o,
   output logic                          m_axis_tvalid_o,
   input  logic                          m_axis_tready_i,

   output logic                          pop_o
);
   import replay_pkg::*;

   mem_word_t                  buf_q [FIFO_DEPTH];
   logic [FIFO_DEPTH_BITS-1:0] wr_ptr_q;
   logic [FIFO_DEPTH_BITS-1:0] rd_ptr_q;
   logic [FIFO_DEPTH_BITS:0]   count_q;
   mem_word_t                  head;

   // Head entry is shown directly on the stream
   assign head            = buf_q[rd_ptr_q];
   assign m_axis_tvalid_o = (count_q != '0);
   assign m_axis_tdata_o  = head.data;
   assign m_axis_tkeep_o  = head.keep;
   assign m_axis_tuser_o  = head.user;
   assign m_axis_tlast_o  = head.last;
   assign pop_o           = m_axis_tvalid_o & m_axis_tready_i;

   // Space is guaranteed by the reader's credit count
   always_ff @(posedge clk_i) begin
      if (rd_valid_i) begin
         buf_q[wr_ptr_q] <= rd_word_i;
      end
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else if (sw_rst_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (rd_valid_i) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
         end
         if (pop_o) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
         case ({rd_valid_i, pop_o})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;
         endcase
      end
   end

endmodule

`default_nettype wire

// File: replay_regs.sv
`timescale 1ns/1ns
`default_nettype none

module replay_regs (
   input  logic                             clk_i,
   input  logic                             arst_n_i,

   // Wishbone classic slave
   input  logic                             wb_cyc_i,
   input  logic                             wb_stb_i,
   input  logic                             wb_we_i,
   input  logic [replay_pkg::WB_ADDR_W-1:0] wb_adr_i,
   input  logic [replay_pkg::WB_DATA_W-1:0] wb_dat_i,
   output logic [replay_pkg::WB_DATA_W-1:0] wb_dat_o,
   output logic                             wb_ack_o,

   // Engine status
   input  logic                             busy_i,
   input  logic [replay_pkg::LEN_W-1:0]     stored_len_i,

   // Engine control
   output logic                             start_o,
   output logic                             sw_rst_o,
   output logic                             wr_done_o,
   output logic [replay_pkg::WB_DATA_W-1:0] replay_count_o
);
   import replay_pkg::*;

   logic                 access;
   logic                 wr_access;
   logic                 rd_access;
   logic [WB_DATA_W-1:0] rd_mux;

   // One access per strobe, finished by the registered ack
   assign access    = wb_cyc_i & wb_stb_i & ~wb_ack_o;
   assign wr_access = access & wb_we_i;
   assign rd_access = access & ~wb_we_i;

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         wb_ack_o       <= 1'b0;
         start_o        <= 1'b0;
         sw_rst_o       <= 1'b0;
         wr_done_o      <= 1'b0;
         replay_count_o <= '0;
      end else begin
         wb_ack_o <= access;
         // Start and soft reset last a single cycle
         start_o  <= 1'b0;
         sw_rst_o <= 1'b0;
         if (wr_access) begin
            case (wb_adr_i)
               REG_CTRL: begin
                  start_o   <= wb_dat_i[CTRL_START_BIT];
                  sw_rst_o  <= wb_dat_i[CTRL_SW_RST_BIT];
                  wr_done_o <= wb_dat_i[CTRL_WR_DONE_BIT];
               end
               REG_COUNT: replay_count_o <= wb_dat_i;
               default:   ;
            endcase
         end
      end
   end

   always_comb begin
      rd_mux = '0;
      case (wb_adr_i)
         REG_CTRL:  rd_mux[CTRL_WR_DONE_BIT] = wr_done_o;
         REG_COUNT: rd_mux = replay_count_o;
         REG_STATUS: begin
            rd_mux[STATUS_BUSY_BIT]         = busy_i;
            rd_mux[STATUS_LEN_LSB +: LEN_W] = stored_len_i;
         end
         default:   rd_mux = '0;
      endcase
   end

   // Read data is sampled with the ack
   always_ff @(posedge clk_i) begin
      if (rd_access) begin
         wb_dat_o <= rd_mux;
      end
   end

endmodule

`default_nettype wire

// File: pkt_replay_top.sv
`timescale 1ns/1ns
`default_nettype none

module pkt_replay_top (
   input  logic                             clk_i,
   input  logic                             arst_n_i,

   // Register bus
   input  logic                             wb_cyc_i,
   input  logic                             wb_stb_i,
   input  logic                             wb_we_i,
   input  logic [replay_pkg::WB_ADDR_W-1:0] wb_adr_i,
   input  logic [replay_pkg::WB_DATA_W-1:0] wb_dat_i,
   output logic [replay_pkg::WB_DATA_W-1:0] wb_dat_o,
   output logic                             wb_ack_o,

   // Capture stream
   input  logic [replay_pkg::DATA_W-1:0]    s_axis_tdata_i,
   input  logic [replay_pkg::KEEP_W-1:0]    s_axis_tkeep_i,
   input  logic [replay_pkg::USER_W-1:0]    s_axis_tuser_i,
   input  logic                             s_axis_tlast_i,
   input  logic                             s_axis_tvalid_i,
   output logic                             s_axis_tready_o,

   // Replay stream
   output logic [replay_pkg::DATA_W-1:0]    m_axis_tdata_o,
   output logic [replay_pkg::KEEP_W-1:0]    m_axis_tkeep_o,
   output logic [replay_pkg::USER_W-1:0]    m_axis_tuser_o,
   output logic                             m_axis_tlast_o,
   output logic                             m_axis_tvalid_o,
   input  logic                             m_axis_tready_i
);
   import replay_pkg::*;

   logic                  start;
   logic                  sw_rst;
   logic                  wr_done;
   logic [WB_DATA_W-1:0]  replay_count;
   logic                  busy;
   logic [LEN_W-1:0]      stored_len;

   logic                  mem_we;
   logic [MEM_ADDR_W-1:0] mem_waddr;
   mem_word_t             mem_wword;
   logic                  rd_req;
   logic [MEM_ADDR_W-1:0] rd_addr;
   logic                  rd_gnt;
   logic                  rd_valid;
   mem_word_t             rd_word;
   logic                  fifo_pop;

   replay_regs regs_i (
      .clk_i            (  clk_i             ),
      .arst_n_i         (  arst_n_i          ),
      .wb_cyc_i         (  wb_cyc_i          ),
      .wb_stb_i         (  wb_stb_i          ),
      .wb_we_i          (  wb_we_i           ),
      .wb_adr_i         (  wb_adr_i          ),
      .wb_dat_i         (  wb_dat_i          ),
      .wb_dat_o         (  wb_dat_o          ),
      .wb_ack_o         (  wb_ack_o          ),
      .busy_i           (  busy              ),
      .stored_len_i     (  stored_len        ),
      .start_o          (  start             ),
      .sw_rst_o         (  sw_rst            ),
      .wr_done_o        (  wr_done           ),
      .replay_count_o   (  replay_count      )
   );

   pkt_capture capture_i (
      .clk_i            (  clk_i             ),
      .arst_n_i         (  arst_n_i          ),
      .s_axis_tdata_i   (  s_axis_tdata_i    ),
      .s_axis_tkeep_i   (  s_axis_tkeep_i    ),
      .s_axis_tuser_i   (  s_axis_tuser_i    ),
      .s_axis_tlast_i   (  s_axis_tlast_i    ),
      .s_axis_tvalid_i  (  s_axis_tvalid_i   ),
      .s_axis_tready_o  (  s_axis_tready_o   ),
      .wr_done_i        (  wr_done           ),
      .sw_rst_i         (  sw_rst            ),
      .mem_we_o         (  mem_we            ),
      .mem_waddr_o      (  mem_waddr         ),
      .mem_wword_o      (  mem_wword         ),
      .stored_len_o     (  stored_len        )
   );

   replay_reader reader_i (
      .clk_i            (  clk_i             ),
      .arst_n_i         (  arst_n_i          ),
      .start_i          (  start             ),
      .sw_rst_i         (  sw_rst            ),
      .replay_count_i   (  replay_count      ),
      .stored_len_i     (  stored_len        ),
      .rd_gnt_i         (  rd_gnt            ),
      .fifo_pop_i       (  fifo_pop          ),
      .rd_req_o         (  rd_req            ),
      .rd_addr_o        (  rd_addr           ),
      .busy_o           (  busy              )
   );

   pkt_mem_arbiter mem_i (
      .clk_i            (  clk_i             ),
      .mem_we_i         (  mem_we            ),
      .mem_waddr_i      (  mem_waddr         ),
      .mem_wword_i      (  mem_wword         ),
      .rd_req_i         (  rd_req            ),
      .rd_addr_i        (  rd_addr           ),
      .rd_gnt_o         (  rd_gnt            ),
      .rd_valid_o       (  rd_valid          ),
      .rd_word_o        (  rd_word           )
   );

   replay_fifo fifo_i (
      .clk_i            (  clk_i             ),
      .arst_n_i         (  arst_n_i          ),
      .sw_rst_i         (  sw_rst            ),
      .rd_valid_i       (  rd_valid          ),
      .rd_word_i        (  rd_word           ),
      .m_axis_tdata_o   (  m_axis_tdata_o    ),
      .m_axis_tkeep_o   (  m_axis_tkeep_o    ),
      .m_axis_tuser_o   (  m_axis_tuser_o    ),
      .m_axis_tlast_o   (  m_axis_tlast_o    ),
      .m_axis_tvalid_o  (  m_axis_tvalid_o   ),
      .m_axis_tready_i  (  m_axis_tready_i   ),
      .pop_o            (  fifo_pop          )
   );

endmodule

`default_nettype wire

// File: tb_pkt_replay_tasks.svh
`ifndef TB_PKT_REPLAY_TASKS_SVH
`define TB_PKT_REPLAY_TASKS_SVH

// Tasks start and end 2 ns after a rising edge

task automatic check_eq(input logic [63:0] got, input logic [63:0] exp, input string what);
   check_count = check_count + 1;
   if (got !== exp) begin
      $display("FAILED at %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
      mismatch_count = mismatch_count + 1;
   end
endtask

task automatic idle_cycles(input int n);
   repeat (n) @(posedge clk_i);
   #DRIVE_DELAY;
endtask

// Classic cycle, held until the ack and released after it
task automatic wb_access(input logic we, input logic [WB_ADDR_W-1:0] addr,
                         input logic [WB_DATA_W-1:0] wdata, output logic [WB_DATA_W-1:0] rdata);
   int waited;
   waited   = 0;
   wb_cyc_i = 1'b1;
   wb_stb_i = 1'b1;
   wb_we_i  = we;
   wb_adr_i = addr;
   wb_dat_i = wdata;
   @(negedge clk_i);
   while (!wb_ack_o && waited < ACK_LIMIT) begin
      waited = waited + 1;
      @(negedge clk_i);
   end
   if (!wb_ack_o) begin
      $display("No ack from the register bus at address %0h", addr);
      fail_count = fail_count + 1;
   end
   rdata = wb_dat_o;
   @(posedge clk_i);
   #DRIVE_DELAY;
   wb_cyc_i = 1'b0;
   wb_stb_i = 1'b0;
   wb_we_i  = 1'b0;
endtask

task automatic wb_write(input logic [WB_ADDR_W-1:0] addr, input logic [WB_DATA_W-1:0] data);
   logic [WB_DATA_W-1:0] unused;
   wb_access(1'b1, addr, data, unused);
endtask

task automatic wb_read(input logic [WB_ADDR_W-1:0] addr, output logic [WB_DATA_W-1:0] data);
   wb_access(1'b0, addr, '0, data);
endtask

// Random beats with last on the final one, kept as the expected stored image
task automatic send_packet(input int len);
   logic [BEAT_W-1:0] beat;
   int                waited;
   int                i;
   stored_q.delete();
   for (i = 0; i < len; i++) begin
      beat = {i == len - 1, USER_W'($urandom), KEEP_W'($urandom), DATA_W'($urandom)};
      stored_q.push_back(beat);
      {s_axis_tlast_i, s_axis_tuser_i, s_axis_tkeep_i, s_axis_tdata_i} = beat;
      s_axis_tvalid_i = 1'b1;
      waited = 0;
      @(negedge clk_i);
      while (!s_axis_tready_o && waited < ACK_LIMIT) begin
         waited = waited + 1;
         @(negedge clk_i);
      end
      if (!s_axis_tready_o) begin
         $display("Capture input never became ready for beat %0d", i);
         fail_count = fail_count + 1;
      end
      @(posedge clk_i);
      #DRIVE_DELAY;
   end
   s_axis_tvalid_i = 1'b0;
   s_axis_tlast_i  = 1'b0;
endtask

task automatic wait_idle();
   logic [WB_DATA_W-1:0] status;
   int                   polls;
   polls = 0;
   wb_read(REG_STATUS, status);
   while (status[0] && polls < POLL_LIMIT) begin
      polls = polls + 1;
      wb_read(REG_STATUS, status);
   end
   if (status[0]) begin
      $display("Replay still busy after %0d status reads", polls);
      fail_count = fail_count + 1;
   end
endtask

// Output must be the stored packet repeated, beat for beat
task automatic compare_replay(input int passes);
   int idx;
   int p;
   int i;
   idx = 0;
   check_eq(out_q.size(), stored_q.size() * passes, "number of replayed beats");
   for (p = 0; p < passes; p++) begin
      for (i = 0; i < stored_q.size(); i++) begin
         if (idx < out_q.size()) begin
            check_eq(out_q[idx], stored_q[i], $sformatf("beat %0d of pass %0d", i, p));
         end
         idx = idx + 1;
      end
   end
   out_q.delete();
endtask

task automatic run_replay(input int passes);
   wb_write(REG_COUNT, passes);
   wb_write(REG_CTRL, (1 << CTRL_WR_DONE_BIT) | (1 << CTRL_START_BIT));
   wait_idle();
   compare_replay(passes);
endtask

task automatic count_reg_readback();
   logic [WB_DATA_W-1:0] value;
   logic [WB_DATA_W-1:0] rd;
   int                   acks_before;
   value       = $urandom;
   acks_before = ack_count;
   wb_write(REG_COUNT, value);
   idle_cycles(2);
   check_eq(ack_count - acks_before, 1, "acks for one write");
   acks_before = ack_count;
   wb_read(REG_COUNT, rd);
   idle_cycles(2);
   check_eq(ack_count - acks_before, 1, "acks for one read");
   check_eq(rd, value, "count register read back");
endtask

task automatic capture_packet();
   logic [WB_DATA_W-1:0] rd;
   check_eq(m_axis_tvalid_o, 0, "output valid after reset");
   check_eq(s_axis_tready_o, 1, "input ready after reset");
   wb_read(REG_STATUS, rd);
   check_eq(rd, 0, "status after reset");
   send_packet(PKT1_LEN);
   wb_write(REG_CTRL, 1 << CTRL_WR_DONE_BIT);
   check_eq(s_axis_tready_o, 0, "input ready with capture closed");
   wb_read(REG_STATUS, rd);
   check_eq(rd, PKT1_LEN << STATUS_LEN_LSB, "stored count after capture");
endtask

task automatic replay_in_order();
   run_replay(PASSES1);
endtask

task automatic replay_with_backpressure();
   rand_ready = 1'b1;
   run_replay(PASSES2);
   rand_ready = 1'b0;
endtask

task automatic zero_count_replay();
   wb_write(REG_COUNT, 0);
   wb_write(REG_CTRL, (1 << CTRL_WR_DONE_BIT) | (1 << CTRL_START_BIT));
   idle_cycles(2 * FIFO_DEPTH);
   wait_idle();
   check_eq(out_q.size(), 0, "beats from a zero count replay");
   out_q.delete();
endtask

task automatic soft_reset_recapture();
   logic [WB_DATA_W-1:0] rd;
   wb_write(REG_CTRL, (1 << CTRL_WR_DONE_BIT) | (1 << CTRL_SW_RST_BIT));
   wb_write(REG_CTRL, 0);
   wb_read(REG_STATUS, rd);
   check_eq(rd, 0, "status after soft reset");
   check_eq(s_axis_tready_o, 1, "input ready after soft reset");
   send_packet(PKT2_LEN);
   wb_write(REG_CTRL, 1 << CTRL_WR_DONE_BIT);
   wb_read(REG_STATUS, rd);
   check_eq(rd, PKT2_LEN << STATUS_LEN_LSB, "stored count of the new packet");
   run_replay(PASSES3);
endtask

`endif

// File: tb_pkt_replay.sv
`timescale 1ns/1ns
`default_nettype none

module tb_pkt_replay;
   import replay_pkg::*;

   localparam int CLK_PERIOD  = 40;
   localparam int DRIVE_DELAY = 2;
   localparam int SEED        = 32'hc610;

   // Packet lengths and replay passes of the directed tests
   localparam int PKT1_LEN = 12;
   localparam int PKT2_LEN = 5;
   localparam int PASSES1  = 3;
   localparam int PASSES2  = 4;
   localparam int PASSES3  = 2;

   // One beat as {last, user, keep, data}
   localparam int BEAT_W = 1 + USER_W + KEEP_W + DATA_W;

   localparam int ACK_LIMIT  = 16;
   localparam int POLL_LIMIT = 200;

   // Every beat in and out, plus bus traffic, with a margin of four
   localparam int TOTAL_BEATS = PKT1_LEN + PKT2_LEN + PKT1_LEN * (PASSES1 + PASSES2)
                                + PKT2_LEN * PASSES3;
   localparam int WATCHDOG_NS = (4 * TOTAL_BEATS + 300) * CLK_PERIOD * 4;

   logic                  clk_i;
   logic                  arst_n_i;
   logic                  wb_cyc_i;
   logic                  wb_stb_i;
   logic                  wb_we_i;
   logic [WB_ADDR_W-1:0]  wb_adr_i;
   logic [WB_DATA_W-1:0]  wb_dat_i;
   logic [WB_DATA_W-1:0]  wb_dat_o;
   logic                  wb_ack_o;
   logic [DATA_W-1:0]     s_axis_tdata_i;
   logic [KEEP_W-1:0]     s_axis_tkeep_i;
   logic [USER_W-1:0]     s_axis_tuser_i;
   logic                  s_axis_tlast_i;
   logic                  s_axis_tvalid_i;
   logic                  s_axis_tready_o;
   logic [DATA_W-1:0]     m_axis_tdata_o;
   logic [KEEP_W-1:0]     m_axis_tkeep_o;
   logic [USER_W-1:0]     m_axis_tuser_o;
   logic                  m_axis_tlast_o;
   logic                  m_axis_tvalid_o;
   logic                  m_axis_tready_i;

   logic                  rand_ready;
   int                    ack_count;
   int                    check_count;
   int                    mismatch_count;
   int                    fail_count;
   logic [BEAT_W-1:0]     stored_q[$];
   logic [BEAT_W-1:0]     out_q[$];

   pkt_replay_top dut_i (.*);

   always #(CLK_PERIOD / 2) clk_i = ~clk_i;

   // Output ready is either held high or toggled at random
   always @(posedge clk_i) begin
      #DRIVE_DELAY;
      m_axis_tready_i = rand_ready ? 1'($urandom) : 1'b1;
   end

   // Everything is sampled at the falling edge, where it is stable
   always @(negedge clk_i) begin
      if (wb_ack_o) begin
         ack_count = ack_count + 1;
      end
      if (m_axis_tvalid_o && m_axis_tready_i) begin
         out_q.push_back({m_axis_tlast_o, m_axis_tuser_o, m_axis_tkeep_o, m_axis_tdata_o});
      end
   end

   `include "tb_pkt_replay_tasks.svh"

   initial begin
      void'($urandom(SEED));
      clk_i           = 1'b0;
      arst_n_i        = 1'b0;
      wb_cyc_i        = 1'b0;
      wb_stb_i        = 1'b0;
      wb_we_i         = 1'b0;
      wb_adr_i        = '0;
      wb_dat_i        = '0;
      s_axis_tdata_i  = '0;
      s_axis_tkeep_i  = '0;
      s_axis_tuser_i  = '0;
      s_axis_tlast_i  = 1'b0;
      s_axis_tvalid_i = 1'b0;
      m_axis_tready_i = 1'b1;
      rand_ready      = 1'b0;
      ack_count       = 0;
      check_count     = 0;
      mismatch_count  = 0;
      fail_count      = 0;

      repeat (3) @(posedge clk_i);
      #DRIVE_DELAY;
      arst_n_i = 1'b1;

      capture_packet();
      count_reg_readback();
      replay_in_order();
      replay_with_backpressure();
      zero_count_replay();
      soft_reset_recapture();
      idle_cycles(4);

      $display("%0d checks, %0d mismatches, %0d other errors",
               check_count, mismatch_count, fail_count);
      if (mismatch_count == 0 && fail_count == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

   initial begin
      #(WATCHDOG_NS);
      $display("Watchdog expired after %0d ns before the tests completed", WATCHDOG_NS);
      $display("TEST FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+.
replay_pkg.sv
pkt_capture.sv
replay_reader.sv
pkt_mem_arbiter.sv
replay_fifo.sv
replay_regs.sv
pkt_replay_top.sv
tb_pkt_replay.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal -j 0
TOP       ?= tb_pkt_replay
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^TEST OK$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
